// ==== line_buf_pkg.sv ====
// widths, strip geometry and shared types for the 8-line strip buffer
// imported by every design unit that handles pixels, words or store addresses
`default_nettype none

package line_buf_pkg;

        localparam int PIX_W          = 8;
        localparam int LANES          = 8;    // pixels per store word
        localparam int WORD_W         = PIX_W * LANES;
        localparam int LINE_PIX       = 1440;
        localparam int WORDS_PER_LINE = LINE_PIX / LANES;
        localparam int STRIP_ROWS     = 8;
        localparam int STORE_DEPTH    = WORDS_PER_LINE * STRIP_ROWS;
        localparam int ADDR_W         = 11;

        // store is split into banks on the top address bits
        localparam int BANK_DEPTH     = 512;
        localparam int BANK_AW        = 9;
        localparam int N_BANKS        = 3;

        typedef logic [PIX_W-1:0]   pix_t;
        typedef pix_t [LANES-1:0]   word_t;   // pixel 0 in the low byte
        typedef logic [LANES-1:0]   ben_t;
        typedef logic [ADDR_W-1:0]  addr_t;
        typedef logic [BANK_AW-1:0] bank_addr_t;

endpackage

`default_nettype wire

// ==== mem_wr_if.sv ====
// write port from the strip writer into the line store
// a write lands at the edge where wr_en is high, only on lanes set in ben
`timescale 1ns/1ps
`default_nettype none

interface mem_wr_if;
        import line_buf_pkg::*;

        logic  wr_en;
        ben_t  ben;    // one-hot per pixel write
        addr_t addr;
        word_t data;

        modport source (
                output wr_en,
                output ben,
                output addr,
                output data
        );

        modport sink (
                input wr_en,
                input ben,
                input addr,
                input data
        );

endinterface

`default_nettype wire

// ==== strip_writer.sv ====
// places raster pixels into the strip store, one byte lane per pixel
// pulses strip_done_o together with the write of the last pixel of row 7
`timescale 1ns/1ps
`default_nettype none

module strip_writer (
        input  wire                  rd_clk_i,
        input  wire                  rst_i,
        input  wire line_buf_pkg::pix_t pix_data_i,
        input  wire                  pix_valid_i,
        mem_wr_if.source             wr,
        output logic                 strip_done_o
);
        import line_buf_pkg::*;

        typedef logic [$clog2(STRIP_ROWS)-1:0] row_t;

        logic [ADDR_W-1:0] col_q;       // 0 .. 1439
        row_t              row_q;
        addr_t             row_base_q;  // row_q * 180, kept as a running sum
        logic              last_col;
        logic              last_row;

        assign last_col = (col_q == ADDR_W'(LINE_PIX - 1));
        assign last_row = (row_q == row_t'(STRIP_ROWS - 1));

        always_ff @(posedge rd_clk_i) begin
                if (rst_i) begin
                        col_q        <= '0;
                        row_q        <= '0;
                        row_base_q   <= '0;
                        wr.wr_en     <= 1'b0;
                        strip_done_o <= 1'b0;
                end else begin
                        wr.wr_en     <= pix_valid_i;
                        strip_done_o <= pix_valid_i && last_col && last_row;
                        if (pix_valid_i) begin
                                if (last_col) begin
                                        col_q <= '0;
                                        if (last_row) begin
                                                row_q      <= '0;
                                                row_base_q <= '0;
                                        end else begin
                                                row_q      <= row_q + row_t'(1);
                                                row_base_q <= row_base_q + ADDR_W'(WORDS_PER_LINE);
                                        end
                                end else begin
                                        col_q <= col_q + ADDR_W'(1);
                                end
                        end
                end
        end

        // write payload, only meaningful while wr_en is high
        always_ff @(posedge rd_clk_i) begin
                if (pix_valid_i) begin
                        wr.addr <= row_base_q + ADDR_W'(col_q[ADDR_W-1:$clog2(LANES)]);
                        wr.ben  <= ben_t'(1) << col_q[$clog2(LANES)-1:0];
                        wr.data <= {LANES{pix_data_i}}; // lane picked by ben
                end
        end

        a_wr_addr_range: assert property (@(posedge rd_clk_i) disable iff (rst_i)
                wr.wr_en |-> (wr.addr <= ADDR_W'(STORE_DEPTH - 1)));

endmodule

`default_nettype wire

// ==== ram_bank.sv ====
// one 512 x 64 behavioral bank, byte lane write enables
// read-first, registered output that holds between reads
`timescale 1ns/1ps
`default_nettype none

module ram_bank (
        input  wire                      rd_clk_i,
        input  wire                      wr_en_i,
        input  wire line_buf_pkg::ben_t  ben_i,
        input  wire line_buf_pkg::bank_addr_t wr_addr_i,
        input  wire line_buf_pkg::bank_addr_t rd_addr_i,
        input  wire line_buf_pkg::word_t wr_data_i,
        input  wire                      rd_en_i,
        output line_buf_pkg::word_t      rd_data_o
);
        import line_buf_pkg::*;

        word_t mem [BANK_DEPTH];

        always_ff @(posedge rd_clk_i) begin
                if (wr_en_i) begin
                        for (int k = 0; k < LANES; k++) begin
                                if (ben_i[k]) begin
                                        mem[wr_addr_i][k] <= wr_data_i[k];
                                end
                        end
                end
        end

        // nonblocking read sees the word before a same-edge write
        always_ff @(posedge rd_clk_i) begin
                if (rd_en_i) begin
                        rd_data_o <= mem[rd_addr_i];
                end
        end

endmodule

`default_nettype wire

// ==== line_store_ram.sv ====
// 1440 x 64 strip store built from three 512-word banks
// bank chosen by the top two address bits, read bank select registered
`timescale 1ns/1ps
`default_nettype none

module line_store_ram (
        input  wire                     rd_clk_i,
        mem_wr_if.sink                  wr,
        input  wire                     rd_en_i,
        input  wire line_buf_pkg::addr_t rd_addr_i,
        output line_buf_pkg::word_t     rd_data_o
);
        import line_buf_pkg::*;

        logic [N_BANKS-1:0] bank_wr_en;
        logic [N_BANKS-1:0] bank_rd_en;
        logic [N_BANKS-1:0] rd_sel_q;   // bank that answers the last read
        word_t              bank_data [N_BANKS];

        for (genvar i = 0; i < N_BANKS; i++) begin : g_bank
                assign bank_wr_en[i] = wr.wr_en &&
                        (wr.addr[ADDR_W-1:BANK_AW] == (ADDR_W - BANK_AW)'(i));
                assign bank_rd_en[i] = rd_en_i &&
                        (rd_addr_i[ADDR_W-1:BANK_AW] == (ADDR_W - BANK_AW)'(i));

                ram_bank u_bank (
                        .rd_clk_i  (rd_clk_i),
                        .wr_en_i   (bank_wr_en[i]),
                        .ben_i     (wr.ben),
                        .wr_addr_i (wr.addr[BANK_AW-1:0]),
                        .rd_addr_i (rd_addr_i[BANK_AW-1:0]),
                        .wr_data_i (wr.data),
                        .rd_en_i   (bank_rd_en[i]),
                        .rd_data_o (bank_data[i])
                );
        end

        always_ff @(posedge rd_clk_i) begin
                if (rd_en_i) begin
                        rd_sel_q <= bank_rd_en;
                end
        end

        // masked OR of the bank outputs
        always_comb begin
                rd_data_o = '0;
                for (int i = 0; i < N_BANKS; i++) begin
                        rd_data_o = rd_data_o | ({WORD_W{rd_sel_q[i]}} & bank_data[i]);
                end
        end

        a_wr_in_store: assert property (@(posedge rd_clk_i)
                wr.wr_en |-> (wr.addr < ADDR_W'(STORE_DEPTH)));
        a_rd_in_store: assert property (@(posedge rd_clk_i)
                rd_en_i |-> (rd_addr_i < ADDR_W'(STORE_DEPTH)));

endmodule

`default_nettype wire

// ==== block_reader.sv ====
// reads a finished strip back in 8x8 block order, rows 0..7 of each word column
// one read per cycle for 1440 cycles, flags delayed to line up with read data
`timescale 1ns/1ps
`default_nettype none

module block_reader (
        input  wire                      rd_clk_i,
        input  wire                      rst_i,
        input  wire                      strip_done_i,
        input  wire line_buf_pkg::word_t rd_data_i,
        output logic                     rd_en_o,
        output line_buf_pkg::addr_t      rd_addr_o,
        output line_buf_pkg::word_t      row_data_o,
        output logic                     row_valid_o,
        output logic                     block_start_o,
        output logic                     strip_end_o
);
        import line_buf_pkg::*;

        typedef logic [$clog2(STRIP_ROWS)-1:0]     row_t;
        typedef logic [$clog2(WORDS_PER_LINE)-1:0] blk_t;

        logic  busy_q;
        row_t  row_q;
        blk_t  blk_q;
        addr_t addr_q;   // row_q * 180 + blk_q
        logic  last_row;
        logic  last_blk;

        assign last_row = (row_q == row_t'(STRIP_ROWS - 1));
        assign last_blk = (blk_q == blk_t'(WORDS_PER_LINE - 1));

        assign rd_en_o    = busy_q;
        assign rd_addr_o  = addr_q;
        assign row_data_o = rd_data_i;   // store output is already registered

        always_ff @(posedge rd_clk_i) begin
                if (rst_i) begin
                        busy_q        <= 1'b0;
                        row_q         <= '0;
                        blk_q         <= '0;
                        addr_q        <= '0;
                        row_valid_o   <= 1'b0;
                        block_start_o <= 1'b0;
                        strip_end_o   <= 1'b0;
                end else begin
                        row_valid_o   <= busy_q;
                        block_start_o <= busy_q && (row_q == '0);
                        strip_end_o   <= busy_q && last_blk && last_row;

                        if (strip_done_i) begin
                                busy_q <= 1'b1;
                                row_q  <= '0;
                                blk_q  <= '0;
                                addr_q <= '0;
                        end else if (busy_q) begin
                                if (last_row) begin
                                        row_q <= '0;
                                        if (last_blk) begin
                                                busy_q <= 1'b0;
                                                blk_q  <= '0;
                                                addr_q <= '0;
                                        end else begin
                                                blk_q  <= blk_q + blk_t'(1);
                                                addr_q <= ADDR_W'(blk_q) + ADDR_W'(1); // row 0, next column
                                        end
                                end else begin
                                        row_q  <= row_q + row_t'(1);
                                        addr_q <= addr_q + ADDR_W'(WORDS_PER_LINE);
                                end
                        end
                end
        end

        // next strip takes far longer to fill than one readout
        a_no_overlap: assert property (@(posedge rd_clk_i) disable iff (rst_i)
                strip_done_i |-> !busy_q);

endmodule

`default_nettype wire

// ==== mcu_line_buffer.sv ====
// raster to 8x8 block-row converter for a 1440-wide greyscale image
// pixels in on a valid strobe, 64-bit block rows out after each 8-line strip
`timescale 1ns/1ps
`default_nettype none

module mcu_line_buffer (
        input  wire                      rd_clk_i,
        input  wire                      rst_i,
        input  wire line_buf_pkg::pix_t  pix_data_i,
        input  wire                      pix_valid_i,
        output line_buf_pkg::word_t      row_data_o,
        output logic                     row_valid_o,
        output logic                     block_start_o,
        output logic                     strip_end_o
);
        import line_buf_pkg::*;

        mem_wr_if wr_bus ();

        logic  strip_done;
        logic  rd_en;
        addr_t rd_addr;
        word_t rd_data;

        strip_writer u_writer (
                .rd_clk_i     (rd_clk_i),
                .rst_i        (rst_i),
                .pix_data_i   (pix_data_i),
                .pix_valid_i  (pix_valid_i),
                .wr           (wr_bus),
                .strip_done_o (strip_done)
        );

        line_store_ram u_store (
                .rd_clk_i  (rd_clk_i),
                .wr        (wr_bus),
                .rd_en_i   (rd_en),
                .rd_addr_i (rd_addr),
                .rd_data_o (rd_data)
        );

        block_reader u_reader (
                .rd_clk_i      (rd_clk_i),
                .rst_i         (rst_i),
                .strip_done_i  (strip_done),
                .rd_data_i     (rd_data),
                .rd_en_o       (rd_en),
                .rd_addr_o     (rd_addr),
                .row_data_o    (row_data_o),
                .row_valid_o   (row_valid_o),
                .block_start_o (block_start_o),
                .strip_end_o   (strip_end_o)
        );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
// testbench clock and reset source with a 100 ns period
// reset is released with a nonblocking update after RST_CYC rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
        parameter int HALF_NS = 50,
        parameter int RST_CYC = 5
) (
        output logic clk_o,
        output logic rst_o
);
        initial begin
                clk_o = 1'b0;
                forever #HALF_NS clk_o = ~clk_o;
        end

        initial begin
                rst_o = 1'b1;
                repeat (RST_CYC) @(posedge clk_o);
                rst_o <= 1'b0;
        end

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
// watches the strip buffer outputs and compares each block row with the sent image
// prints one line per test and a closing count line, then raises done_o
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
        parameter int N_STRIPS = 3
) (
        input  wire                      clk_i,
        input  wire                      rst_i,
        input  wire                      pix_valid_i,
        input  wire line_buf_pkg::pix_t  img_i [N_STRIPS][line_buf_pkg::STRIP_ROWS]
                                               [line_buf_pkg::LINE_PIX],
        input  wire line_buf_pkg::word_t row_data_i,
        input  wire                      row_valid_i,
        input  wire                      block_start_i,
        input  wire                      strip_end_i,
        output logic                     done_o,
        output int                       err_cnt_o
);
        import line_buf_pkg::*;

        localparam int STRIP_PIX = LINE_PIX * STRIP_ROWS;
        localparam int STRIP_OUT = WORDS_PER_LINE * STRIP_ROWS;   // rows per strip
        localparam int LATENCY   = 3;   // last pixel edge to first valid row

        int   cyc;
        int   pix_cnt;
        int   sent;
        int   out_strip;
        int   out_row;
        int   tail_strip;   // strip whose last row came on the previous edge
        int   last_edge [N_STRIPS];
        int   err_quiet;
        int   err_data  [N_STRIPS];
        int   err_flag  [N_STRIPS];
        int   err_burst [N_STRIPS];
        int   tests;
        int   fails;
        int   total;
        logic prev_valid;

        initial begin
                cyc        = 0;
                pix_cnt    = 0;
                sent       = 0;
                out_strip  = 0;
                out_row    = 0;
                tail_strip = -1;
                err_quiet  = 0;
                tests      = 0;
                fails      = 0;
                prev_valid = 1'b0;
                done_o     = 1'b0;
                err_cnt_o  = 0;
                for (int i = 0; i < N_STRIPS; i++) begin
                        last_edge[i] = 0;
                        err_data[i]  = 0;
                        err_flag[i]  = 0;
                        err_burst[i] = 0;
                end
        end

        // row r of word column b with the lower column in the lower byte
        function automatic word_t expected_row(input int s, input int b, input int r);
                word_t w;
                for (int k = 0; k < LANES; k++) begin
                        w[k] = img_i[s][r][b * LANES + k];
                end
                return w;
        endfunction

        task automatic report(input string name, input int errs);
                tests++;
                if (errs != 0) fails++;
                $display("test %s: %s, %0d errors", name, (errs == 0) ? "ok" : "fail", errs);
        endtask

        task automatic close_run();
                total = err_quiet;
                for (int i = 0; i < N_STRIPS; i++) begin
                        total += err_data[i] + err_flag[i] + err_burst[i];
                end
                $display("checker: %0d tests, %0d failed, %0d errors", tests, fails, total);
                err_cnt_o <= total;
                done_o    <= 1'b1;
        endtask

        task automatic check_row();
                int    s;
                int    b;
                int    r;
                word_t exp_w;
                logic  exp_start;
                logic  exp_end;
                s = out_strip;
                b = out_row / STRIP_ROWS;
                r = out_row % STRIP_ROWS;
                if (out_row == 0) begin
                        if (s >= sent) begin
                                $display("rows of strip %0d came before its last pixel", s);
                                err_burst[s]++;
                        end else if (cyc != last_edge[s] + LATENCY) begin
                                $display("error strip%0d_burst latency: expected %0d actual %0d",
                                         s, LATENCY, cyc - last_edge[s]);
                                err_burst[s]++;
                        end
                end else if (!prev_valid) begin
                        $display("strip %0d output burst broken before row %0d", s, out_row);
                        err_burst[s]++;
                end
                exp_w     = expected_row(s, b, r);
                exp_start = (r == 0);
                exp_end   = (out_row == STRIP_OUT - 1);
                if (row_data_i !== exp_w) begin
                        $display("error strip%0d_data block %0d row %0d: expected %h actual %h",
                                 s, b, r, exp_w, row_data_i);
                        err_data[s]++;
                end
                if (block_start_i !== exp_start || strip_end_i !== exp_end) begin
                        $display("error strip%0d_flags block %0d row %0d: expected %b%b actual %b%b",
                                 s, b, r, exp_start, exp_end, block_start_i, strip_end_i);
                        err_flag[s]++;
                end
                out_row++;
                if (out_row == STRIP_OUT) begin
                        out_row    = 0;
                        tail_strip = s;
                end
        endtask

        // output must be idle on the edge after the last row of a strip
        task automatic end_strip();
                int s;
                s = tail_strip;
                if (row_valid_i || block_start_i || strip_end_i) begin
                        $display("strip %0d output went on past %0d rows, cycle %0d",
                                 s, STRIP_OUT, cyc);
                        err_burst[s]++;
                end
                report($sformatf("strip%0d_data", s), err_data[s]);
                report($sformatf("strip%0d_flags", s), err_flag[s]);
                report($sformatf("strip%0d_burst", s), err_burst[s]);
                if (s == 1) report("back_to_back", err_data[0] + err_data[1]);
                tail_strip = -1;
                out_strip++;
                if (out_strip == N_STRIPS) close_run();
        endtask

        always @(posedge clk_i) begin
                cyc = cyc + 1;
                if ((rst_i || sent == 0) && (row_valid_i || block_start_i || strip_end_i)) begin
                        $display("output active before the first strip was sent, cycle %0d", cyc);
                        err_quiet++;
                end
                if (!rst_i && pix_valid_i) begin
                        pix_cnt++;
                        if (pix_cnt == STRIP_PIX) begin
                                pix_cnt = 0;
                                if (sent < N_STRIPS) last_edge[sent] = cyc;
                                sent++;
                                if (sent == 1) report("reset_quiet", err_quiet);
                        end
                end
                if (!rst_i && !done_o && sent > 0) begin
                        if (tail_strip >= 0) begin
                                end_strip();
                        end else if (row_valid_i) begin
                                check_row();
                        end else if (block_start_i || strip_end_i) begin
                                $display("flag raised without a valid row, cycle %0d", cyc);
                                err_flag[(out_strip < N_STRIPS) ? out_strip : N_STRIPS - 1]++;
                        end
                end
                prev_valid = row_valid_i;
        end

endmodule

`default_nettype wire

// ==== tb_mcu_line_buffer.sv ====
// testbench top for the strip buffer: random pixels for three strips,
// keeps the sent image for the checker and ends the run on done or timeout
`timescale 1ns/1ps
`default_nettype none

module tb_mcu_line_buffer;
        import line_buf_pkg::*;

        localparam int N_STRIPS    = 3;
        localparam int STRIP_PIX   = LINE_PIX * STRIP_ROWS;
        localparam int TIMEOUT_CYC = N_STRIPS * STRIP_PIX * 2 + 2000;

        logic  clk;
        logic  rst;
        pix_t  pix_data;
        logic  pix_valid;
        word_t row_data;
        logic  row_valid;
        logic  block_start;
        logic  strip_end;
        logic  chk_done;
        int    chk_errors;
        int    seed;
        int    cyc = 0;

        pix_t  img [N_STRIPS][STRIP_ROWS][LINE_PIX];   // every pixel sent, by strip

        tb_clock_gen u_clk (
                .clk_o (clk),
                .rst_o (rst)
        );

        mcu_line_buffer dut0 (
                .rd_clk_i      (clk),
                .rst_i         (rst),
                .pix_data_i    (pix_data),
                .pix_valid_i   (pix_valid),
                .row_data_o    (row_data),
                .row_valid_o   (row_valid),
                .block_start_o (block_start),
                .strip_end_o   (strip_end)
        );

        tb_checker #(.N_STRIPS(N_STRIPS)) u_chk (
                .clk_i         (clk),
                .rst_i         (rst),
                .pix_valid_i   (pix_valid),
                .img_i         (img),
                .row_data_i    (row_data),
                .row_valid_i   (row_valid),
                .block_start_i (block_start),
                .strip_end_i   (strip_end),
                .done_o        (chk_done),
                .err_cnt_o     (chk_errors)
        );

        // one strip in raster order, idle cycles at about 30% when gaps is set
        task automatic send_strip(input int s, input bit gaps);
                pix_t v;
                bit   sent;
                for (int r = 0; r < STRIP_ROWS; r++) begin
                        for (int c = 0; c < LINE_PIX; c++) begin
                                sent = 1'b0;
                                while (!sent) begin
                                        @(posedge clk);
                                        v = pix_t'($random(seed));
                                        if (!gaps || ($unsigned($random(seed)) % 100) < 70) begin
                                                pix_valid   <= 1'b1;
                                                pix_data    <= v;
                                                img[s][r][c] = v;
                                                sent         = 1'b1;
                                        end else begin
                                                pix_valid <= 1'b0;
                                                pix_data  <= v;   // junk on idle cycles
                                        end
                                end
                        end
                end
        endtask

        initial begin
                seed      = 32'h98d57437;
                pix_valid = 1'b0;
                pix_data  = '0;
                @(posedge clk);
                while (rst) @(posedge clk);
                send_strip(0, 1'b1);
                send_strip(1, 1'b0);   // back to back, full rate
                send_strip(2, 1'b1);
                @(posedge clk);
                pix_valid <= 1'b0;
                while (!chk_done) @(posedge clk);
                if (chk_errors == 0) begin
                        $display("TB PASSED");
                end else begin
                        $display("TB FAILED");
                end
                $finish;
        end

        always @(posedge clk) begin
                cyc <= cyc + 1;
                if (cyc == TIMEOUT_CYC) begin
                        $display("timeout after %0d cycles, not all strips were read out", cyc);
                        $display("TB FAILED");
                        $finish;
                end
        end

endmodule

`default_nettype wire

// ==== files.f ====
line_buf_pkg.sv
mem_wr_if.sv
strip_writer.sv
ram_bank.sv
line_store_ram.sv
block_reader.sv
mcu_line_buffer.sv
tb_clock_gen.sv
tb_checker.sv
tb_mcu_line_buffer.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and decide the result from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_mcu_line_buffer -f files.f -o sim_tb \
        && ./obj_dir/sim_tb > sim.log 2>&1 \
        || { echo "build or run of the simulation failed"; exit 1; }
cat sim.log
grep -q "^TB PASSED$" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }
